//--- huffman_encoder.f
hw/huff_pkg.sv
hw/huff_step_counter.sv
hw/huff_node_sorter.sv
hw/huff_tree_builder.sv
hw/huff_ctrl_fsm.sv
hw/huff_top.sv
testbench/huff_top_tb.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= huff_top_tb
FILELIST ?= huffman_encoder.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- testbench/huff_top_tb.sv
// testbench for the huffman encoder top
// applies a table of weight sets and modes, builds the expected code
// stream with a reference huffman model and checks out_valid/out_code

`timescale 1ns/1ps

module huff_top_tb;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_FIXED       = 6;
    localparam int NUM_RANDOM      = 8;
    localparam int NUM_CASES       = NUM_FIXED + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_CASES * 60 + 50;
    localparam int START_TIMEOUT   = 30;
    localparam int MAX_STREAM      = 64;

    // one row of stimulus with its expected stream
    typedef struct packed {
        logic            mode;
        logic [0:7][2:0] weights;
        logic [63:0]     exp_bits;
        logic [7:0]      exp_len;
    } case_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid;
    logic       out_mode;
    logic [2:0] in_weight;
    logic       out_valid;
    logic       out_code;

    case_t cases [NUM_CASES];
    int    error_count;
    int    check_count;

    huff_top huff_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_mode  (out_mode),
        .in_weight (in_weight),
        .out_valid (out_valid),
        .out_code  (out_code)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input int actual, input int expected);
        check_count++;
        if (actual != expected)
        begin
            $display("mismatch at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // a ranks below b: lighter, or same weight and lower id
    function automatic bit ranks_below(input int wa, input int ida, input int wb, input int idb);
        return (wa < wb) || ((wa == wb) && (ida < idb));
    endfunction

    // ====================
    // reference model
    // ====================
    // weights[0] is A (id 14) down to weights[7] is V (id 7)
    task automatic build_expected(input logic mode, input logic [0:7][2:0] w,
                                  output logic [63:0] bits, output logic [7:0] len);
        int weight [15];
        bit live [15];
        int parent [15];
        bit branch [15];
        bit path [8];
        int order [5];
        int low_id;
        int sec_id;
        int next_id;
        int node;
        int depth;
        int len_i;
        for (int i = 0; i < 15; i++)
        begin
            weight[i] = 0;
            live[i]   = 1'b0;
            parent[i] = -1;
            branch[i] = 1'b0;
        end
        for (int k = 0; k < 8; k++)
        begin
            weight[14 - k] = int'(w[k]);
            live[14 - k]   = 1'b1;
        end
        next_id = 6;
        repeat (7)
        begin
            low_id = -1;
            sec_id = -1;
            for (int id = 0; id < 15; id++)
            begin
                if (!live[id])
                    continue;
                if (low_id < 0 || ranks_below(weight[id], id, weight[low_id], low_id))
                begin
                    sec_id = low_id;
                    low_id = id;
                end
                else if (sec_id < 0 || ranks_below(weight[id], id, weight[sec_id], sec_id))
                    sec_id = id;
            end
            parent[low_id]  = next_id;
            branch[low_id]  = 1'b1;
            parent[sec_id]  = next_id;
            branch[sec_id]  = 1'b0;
            live[low_id]    = 1'b0;
            live[sec_id]    = 1'b0;
            weight[next_id] = weight[low_id] + weight[sec_id];
            live[next_id]   = 1'b1;
            next_id--;
        end
        if (mode)
            order = '{4, 2, 5, 0, 1};
        else
            order = '{4, 5, 6, 7, 3};
        bits  = '0;
        len_i = 0;
        for (int s = 0; s < 5; s++)
        begin
            // walk leaf to root, then send root first
            node  = 14 - order[s];
            depth = 0;
            while (parent[node] >= 0)
            begin
                path[depth] = branch[node];
                node        = parent[node];
                depth++;
            end
            for (int d = depth - 1; d >= 0; d--)
            begin
                bits[len_i] = path[d];
                len_i++;
            end
        end
        len = 8'(len_i);
    endtask

    task automatic set_case(input int idx, input logic mode, input logic [0:7][2:0] w);
        cases[idx].mode    = mode;
        cases[idx].weights = w;
    endtask

    task automatic fill_table();
        logic [63:0] bits;
        logic [7:0]  len;
        set_case(0, 1'b0, {3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0});
        set_case(1, 1'b1, {3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0});
        // all tied, order comes from ids only
        set_case(2, 1'b0, {3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3});
        set_case(3, 1'b1, {3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3});
        set_case(4, 1'b0, {3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0});
        set_case(5, 1'b1, {3'd2, 3'd5, 3'd0, 3'd7, 3'd1, 3'd6, 3'd3, 3'd4});
        for (int i = NUM_FIXED; i < NUM_CASES; i++)
        begin
            cases[i].mode = 1'($urandom % 2);
            for (int k = 0; k < 8; k++)
                cases[i].weights[k] = 3'($urandom % 8);
        end
        for (int i = 0; i < NUM_CASES; i++)
        begin
            build_expected(cases[i].mode, cases[i].weights, bits, len);
            cases[i].exp_bits = bits;
            cases[i].exp_len  = len;
        end
    endtask

    // ====================
    // one case: load, wait, collect
    // ====================
    task automatic run_case(input int c);
        int wait_cycles;
        int got_len;
        for (int k = 0; k < 8; k++)
        begin
            @(posedge clk);
            #1;
            in_valid  = 1'b1;
            in_weight = cases[c].weights[k];
            // mode only counts on the first weight
            out_mode  = (k == 0) ? cases[c].mode : ~cases[c].mode;
            @(negedge clk);
            check_value($sformatf("out_valid during load, case %0d", c), int'(out_valid), 0);
        end
        @(posedge clk);
        #1;
        in_valid  = 1'b0;
        in_weight = 3'd0;
        out_mode  = 1'b0;
        wait_cycles = 0;
        @(negedge clk);
        while (!out_valid && wait_cycles < START_TIMEOUT)
        begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!out_valid)
        begin
            $display("case %0d: out_valid never came up after the last weight", c);
            error_count++;
            return;
        end
        got_len = 0;
        while (out_valid && got_len < MAX_STREAM)
        begin
            if (got_len < int'(cases[c].exp_len))
                check_value($sformatf("out_code bit %0d, case %0d", got_len, c),
                            int'(out_code), int'(cases[c].exp_bits[got_len]));
            got_len++;
            @(negedge clk);
        end
        check_value($sformatf("out_valid length, case %0d", c), got_len,
                    int'(cases[c].exp_len));
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        out_mode    = 1'b0;
        in_weight   = 3'd0;
        error_count = 0;
        check_count = 0;
        void'($urandom(16));
        fill_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid after reset", int'(out_valid), 0);
        check_value("out_code after reset", int'(out_code), 0);
        for (int c = 0; c < NUM_CASES; c++)
            run_case(c);
        $display("cases: %0d, checks: %0d, errors: %0d", NUM_CASES, check_count, error_count);
        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- hw/huff_top.sv
// huffman encoder top
// takes eight 3-bit symbol weights and streams five huffman codes,
// root bit first, in the order picked by out_mode

`timescale 1ns/1ps

module huff_top
    import huff_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       out_mode,
    input  logic [2:0] in_weight,
    output logic       out_valid,
    output logic       out_code
);

    logic      load_en;
    logic      merge_en;
    logic      emit_en;
    logic      step_clear;
    node_id_t  load_slot;
    node_id_t  merge_id;
    emit_req_t emit;
    code_len_t sym_len;

    huff_ctrl_fsm huff_ctrl_fsm_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .out_mode   (out_mode),
        .sym_len    (sym_len),
        .load_en    (load_en),
        .merge_en   (merge_en),
        .emit_en    (emit_en),
        .load_slot  (load_slot),
        .merge_id   (merge_id),
        .emit       (emit),
        .step_clear (step_clear),
        .out_valid  (out_valid)
    );

    // codes and masks are wiped whenever the controller sits idle
    huff_tree_builder huff_tree_builder_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_slot (load_slot),
        .in_weight (in_weight),
        .merge_en  (merge_en),
        .merge_id  (merge_id),
        .emit_en   (emit_en),
        .emit      (emit),
        .clear     (step_clear),
        .sym_len   (sym_len),
        .out_code  (out_code)
    );

endmodule

//--- hw/huff_ctrl_fsm.sv
// phase controller
// idle -> load (8 weights) -> build (7 merges) -> emit (5 codes) -> idle
// steers the tree builder and derives slots, merge ids and bit indexes
// from the shared step counter

`timescale 1ns/1ps

module huff_ctrl_fsm
    import huff_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  logic      out_mode,
    input  code_len_t sym_len,
    output logic      load_en,
    output logic      merge_en,
    output logic      emit_en,
    output node_id_t  load_slot,
    output node_id_t  merge_id,
    output emit_req_t emit,
    output logic      step_clear,
    output logic      out_valid
);

    phase_e     phase;
    phase_e     phase_next;
    logic       mode;
    logic [2:0] slot;
    logic [3:0] step_limit;
    logic [3:0] step_count;
    logic       step_last;

    huff_step_counter huff_step_counter_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (step_clear),
        .limit (step_limit),
        .count (step_count),
        .last  (step_last)
    );

    // ====================
    // step control
    // ====================
    // hold the counter at zero while waiting for the first weight
    assign step_clear = (phase == phase_idle) && !in_valid;

    always_comb
    begin
        case (phase)
            phase_build: step_limit = 4'(NUM_MERGES - 1);
            phase_emit:  step_limit = {1'b0, sym_len} - 4'd1;
            default:     step_limit = 4'(NUM_SYMBOLS - 1);
        endcase
    end

    // first weight arrives while still idle
    assign load_en   = (phase == phase_load) || ((phase == phase_idle) && in_valid);
    assign load_slot = LAST_LEAF_ID - step_count;

    assign merge_en = (phase == phase_build);
    assign merge_id = FIRST_MERGE_ID - step_count;

    assign emit_en      = (phase == phase_emit);
    assign emit.sym     = emit_symbol(mode, slot);
    assign emit.bit_idx = step_count[2:0];

    // ====================
    // next phase
    // ====================
    always_comb
    begin
        phase_next = phase;
        case (phase)
            phase_idle:
                if (in_valid)
                    phase_next = phase_load;
            phase_load:
                if (step_last)
                    phase_next = phase_build;
            phase_build:
                if (step_last)
                    phase_next = phase_emit;
            phase_emit:
                if (step_last && (slot == 3'(EMIT_COUNT - 1)))
                    phase_next = phase_idle;
            default:
                phase_next = phase_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase     <= phase_idle;
            mode      <= 1'b0;
            slot      <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            phase     <= phase_next;
            out_valid <= emit_en;
            // mode rides with the first weight
            if ((phase == phase_idle) && in_valid)
                mode <= out_mode;
            // next symbol after its last bit
            if (emit_en && step_last)
                slot <= (slot == 3'(EMIT_COUNT - 1)) ? 3'd0 : slot + 3'd1;
        end
    end

endmodule

//--- hw/huff_tree_builder.sv
// huffman tree datapath
// holds the live node list with weights, the symbol masks of merged
// subtrees and the per-symbol codes and lengths; one merge per cycle,
// then serves code bits one at a time onto out_code

`timescale 1ns/1ps

module huff_tree_builder
    import huff_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_en,
    input  node_id_t   load_slot,
    input  in_weight_t in_weight,
    input  logic       merge_en,
    input  node_id_t   merge_id,
    input  logic       emit_en,
    input  emit_req_t  emit,
    input  logic       clear,
    output code_len_t  sym_len,
    output logic       out_code
);

    typedef logic [NUM_SYMBOLS-1:0] sym_mask_t;

    node_t      nodes [NUM_SYMBOLS];
    node_t      lowest;
    node_t      second;
    weight_t    merged_weight;
    sym_mask_t  sub_mask [NUM_MERGES];
    sym_mask_t  low_mask;
    sym_mask_t  sec_mask;
    code_t      code [NUM_SYMBOLS];
    code_len_t  code_len [NUM_SYMBOLS];
    logic [2:0] load_idx;
    logic [2:0] emit_idx;

    huff_node_sorter huff_node_sorter_inst (
        .nodes  (nodes),
        .lowest (lowest),
        .second (second)
    );

    function automatic sym_mask_t leaf_mask(input node_id_t id);
        return NUM_SYMBOLS'(1) << (id - FIRST_LEAF_ID);
    endfunction

    assign load_idx      = 3'(load_slot - FIRST_LEAF_ID);
    assign emit_idx      = 3'(emit.sym - FIRST_LEAF_ID);
    assign merged_weight = lowest.weight + second.weight;
    assign sym_len       = code_len[emit_idx];

    // symbols under each of the two merged nodes
    always_comb
    begin
        if (lowest.id >= FIRST_LEAF_ID)
            low_mask = leaf_mask(lowest.id);
        else
            low_mask = sub_mask[lowest.id[2:0]];
        if (second.id >= FIRST_LEAF_ID)
            sec_mask = leaf_mask(second.id);
        else
            sec_mask = sub_mask[second.id[2:0]];
    end

    // ====================
    // node list
    // ====================
    // merged node takes the slot of the lowest, second slot is retired
    always_ff @(posedge clk)
    begin
        if (load_en)
            nodes[load_idx] <= '{id: load_slot, weight: weight_t'(in_weight)};
        else if (merge_en)
        begin
            for (int k = 0; k < NUM_SYMBOLS; k++)
            begin
                if (nodes[k].id == lowest.id)
                    nodes[k] <= '{id: merge_id, weight: merged_weight};
                else if (nodes[k].id == second.id)
                    nodes[k] <= DEAD_NODE;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            for (int m = 0; m < NUM_MERGES; m++)
                sub_mask[m] <= '0;
        end
        else if (merge_en)
            sub_mask[merge_id[2:0]] <= low_mask | sec_mask;
    end

    // ====================
    // codes and lengths
    // ====================
    // new bit enters at the lsb, so the root bit ends up at bit 0
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            for (int s = 0; s < NUM_SYMBOLS; s++)
                code[s] <= '0;
        end
        else if (merge_en)
        begin
            for (int s = 0; s < NUM_SYMBOLS; s++)
            begin
                if (low_mask[s])
                    code[s] <= {code[s][MAX_CODE_LEN-2:0], 1'b1};
                else if (sec_mask[s])
                    code[s] <= {code[s][MAX_CODE_LEN-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < NUM_SYMBOLS; s++)
                code_len[s] <= '0;
        end
        else if (clear)
        begin
            for (int s = 0; s < NUM_SYMBOLS; s++)
                code_len[s] <= '0;
        end
        else if (merge_en)
        begin
            for (int s = 0; s < NUM_SYMBOLS; s++)
            begin
                if (low_mask[s] || sec_mask[s])
                    code_len[s] <= code_len[s] + 3'd1;
            end
        end
    end

    // output bit, low outside the stream
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_code <= 1'b0;
        else if (emit_en)
            out_code <= code[emit_idx][emit.bit_idx];
        else
            out_code <= 1'b0;
    end

endmodule

//--- hw/huff_node_sorter.sv
// node ranking network
// ranks eight nodes by descending weight, higher id first on a tie,
// and returns the last and second-to-last ranked nodes

`timescale 1ns/1ps

module huff_node_sorter
    import huff_pkg::*;
(
    input  node_t nodes [NUM_SYMBOLS],
    output node_t lowest,
    output node_t second
);

    // number of nodes ranked above each entry
    logic [2:0] rank [NUM_SYMBOLS];

    function automatic logic outranks(input node_t a, input node_t b);
        return (a.weight > b.weight) || ((a.weight == b.weight) && (a.id > b.id));
    endfunction

    // ====================
    // pairwise compare
    // ====================
    always_comb
    begin
        for (int i = 0; i < NUM_SYMBOLS; i++)
        begin
            rank[i] = '0;
            for (int j = 0; j < NUM_SYMBOLS; j++)
            begin
                if (outranks(nodes[j], nodes[i]))
                    rank[i] = rank[i] + 3'd1;
            end
        end
    end

    // dead entries tie among themselves but always sit on top,
    // so the two bottom ranks are unique while two live nodes remain
    always_comb
    begin
        lowest = DEAD_NODE;
        second = DEAD_NODE;
        for (int i = 0; i < NUM_SYMBOLS; i++)
        begin
            if (rank[i] == 3'(NUM_SYMBOLS - 1))
                lowest = nodes[i];
            if (rank[i] == 3'(NUM_SYMBOLS - 2))
                second = nodes[i];
        end
    end

endmodule

//--- hw/huff_step_counter.sv
// step counter
// counts up each cycle and flags the cycle where it reaches the limit,
// then wraps to zero on its own; one counter serves load, build and emit

`timescale 1ns/1ps

module huff_step_counter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic [3:0] limit,
    output logic [3:0] count,
    output logic       last
);

    assign last = (count == limit);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            count <= '0;
        else if (clear || last)
            count <= '0;
        else
            count <= count + 4'd1;
    end

endmodule

//--- hw/huff_pkg.sv
// huffman code builder package
// sizes, node and request types, phase and symbol encodings,
// and the per-mode order in which symbol codes are streamed out

package huff_pkg;

    // ====================
    // sizes
    // ====================
    localparam int NUM_SYMBOLS  = 8;
    localparam int NUM_MERGES   = 7;
    localparam int MAX_CODE_LEN = 7;
    localparam int EMIT_COUNT   = 5;

    // ====================
    // types
    // ====================
    typedef logic [2:0]              in_weight_t;
    typedef logic [5:0]              weight_t;
    typedef logic [3:0]              node_id_t;
    typedef logic [MAX_CODE_LEN-1:0] code_t;
    typedef logic [2:0]              code_len_t;

    // leaf ids, A is the highest
    typedef enum logic [3:0] {
        sym_v = 4'd7,
        sym_o = 4'd8,
        sym_l = 4'd9,
        sym_i = 4'd10,
        sym_e = 4'd11,
        sym_c = 4'd12,
        sym_b = 4'd13,
        sym_a = 4'd14
    } symbol_e;

    typedef enum logic [1:0] {
        phase_idle,
        phase_load,
        phase_build,
        phase_emit
    } phase_e;

    typedef struct packed {
        node_id_t id;
        weight_t  weight;
    } node_t;

    typedef struct packed {
        symbol_e    sym;
        logic [2:0] bit_idx;
    } emit_req_t;

    // node ids
    localparam node_id_t FIRST_MERGE_ID = 4'd6;
    localparam node_id_t FIRST_LEAF_ID  = 4'd7;
    localparam node_id_t LAST_LEAF_ID   = 4'd14;

    // removed entry, outranks every live node
    localparam node_t DEAD_NODE = '{id: 4'hf, weight: 6'h3f};

    // symbol sent in a given slot of the output stream
    function automatic symbol_e emit_symbol(input logic mode, input logic [2:0] slot);
        symbol_e sym;
        if (!mode)
        begin
            case (slot)
                3'd0:    sym = sym_i;
                3'd1:    sym = sym_l;
                3'd2:    sym = sym_o;
                3'd3:    sym = sym_v;
                default: sym = sym_e;
            endcase
        end
        else
        begin
            case (slot)
                3'd0:    sym = sym_i;
                3'd1:    sym = sym_c;
                3'd2:    sym = sym_l;
                3'd3:    sym = sym_a;
                default: sym = sym_b;
            endcase
        end
        return sym;
    endfunction

endpackage
